// ==== run_sim.sh ====
#!/bin/sh
# build and run the dmem port testbench with verilator

cd "$(dirname "$0")" || exit 1

log=sim.log

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module dmem_port_tb -f vlog.f -o dmem_port_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

# raised error limit so every failed assertion is counted
./obj_dir/dmem_port_sim +verilator+error+limit+1000 > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "^=== PASS ===$" "$log"; then
    echo "simulation passed"
    exit 0
fi
echo "simulation failed, see $log"
exit 1

// ==== sim/dmem_port_assert.sv ====
`timescale 1ns/1ps
`default_nettype none

module dmem_port_assert (
    input logic                clk,
    input logic                rst,
    input dmem_pkg::bus_req_t  bus_req,
    input dmem_pkg::bus_resp_t bus_resp,
    input logic                stall,
    input logic                addr_rcv   // bridge waits for data_ok
);

    int fail_cnt = 0;  // failed protocol checks

    // request and all its fields frozen until the address is taken
    a_req_stable: assert property (@(posedge clk) disable iff (rst)
        bus_req.req && !bus_resp.addr_ok |=> bus_req.req && $stable(bus_req))
    else begin
        fail_cnt++;
        $error("bus request dropped or changed before addr_ok");
    end

    // data_ok only for an access in flight
    a_data_owned: assert property (@(posedge clk) disable iff (rst)
        bus_resp.data_ok |-> addr_rcv || (bus_req.req && bus_resp.addr_ok))
    else begin
        fail_cnt++;
        $error("data_ok without an outstanding access");
    end

    a_req_stalls: assert property (@(posedge clk) disable iff (rst)
        bus_req.req |-> stall)  // a request always holds the pipeline
    else begin
        fail_cnt++;
        $error("bus request while stall is low");
    end

endmodule

`default_nettype wire

// ==== sim/dmem_port_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "dmem_settings.svh"

module dmem_port_tb;

    import dmem_pkg::*;

    localparam int n_random   = 200;
    localparam int n_directed = 23;
    localparam int max_cycles = 40 * (n_directed + n_random);

    logic                    clk;
    logic                    rst;
    mem_req_t                mem_req;
    logic                    hold;
    logic                    stall;
    logic [`DMEM_DATA_W-1:0] load_data;
    bus_req_t                bus_req;
    bus_resp_t               bus_resp;
    logic                    zero_delay;

    logic [7:0]              ref_mem [0:255];  // reference byte memory
    logic [`DMEM_DATA_W-1:0] exp_load;
    logic                    load_check;      // current access is a load
    int                      errors;
    int                      issued;          // accesses sent to the DUT
    int                      addr_ok_cnt;
    int                      proto_errs;
    int                      cycles = 0;
    integer                  seed;

    initial clk = 1'b0;
    always #4 clk = ~clk;

    dmem_port_top i_dut (
        .clk       (clk),
        .rst       (rst),
        .mem_req   (mem_req),
        .hold      (hold),
        .stall     (stall),
        .load_data (load_data),
        .bus_req   (bus_req),
        .bus_resp  (bus_resp)
    );

    sram_like_mem i_mem (
        .clk        (clk),
        .rst        (rst),
        .zero_delay (zero_delay),
        .bus_req    (bus_req),
        .bus_resp   (bus_resp)
    );

    bind sram_like_bridge dmem_port_assert i_proto_assert (
        .clk      (clk),
        .rst      (rst),
        .bus_req  (bus_req),
        .bus_resp (bus_resp),
        .stall    (stall),
        .addr_rcv (addr_rcv)
    );

    assign proto_errs = i_dut.i_bridge.i_proto_assert.fail_cnt;

    always @(posedge clk) begin
        if (rst) addr_ok_cnt <= 0;
        else if (bus_resp.addr_ok) addr_ok_cnt <= addr_ok_cnt + 1;  // one per address phase
    end

    // load result valid while the finished access sits in mem stage
    a_load_result: assert property (@(posedge clk) disable iff (rst)
        load_check && mem_req.en && !stall |-> load_data == exp_load)
    else begin
        errors++;
        $display("error at %0t: load_data = %h, expected %h", $time,
                 $sampled(load_data), $sampled(exp_load));
    end

    a_idle_quiet: assert property (@(posedge clk) !mem_req.en |-> !bus_req.req && !stall)
    else begin
        errors++;
        $display("error at %0t: req/stall = %b%b with en low, expected 00", $time,
                 $sampled(bus_req.req), $sampled(stall));
    end

    function automatic logic [7:0] fill_byte(input int a);
        fill_byte = a[7:0] * 8'd29 ^ 8'hc3;  // same start content as the slave
    endfunction

    function automatic mem_width_t pick_width(input logic [1:0] code);
        case (code)
            2'd0:    pick_width = mem_byte;
            2'd1:    pick_width = mem_half;
            default: pick_width = mem_word;
        endcase
    endfunction

    // little endian, extended by the load type
    function automatic logic [31:0] expected_load(input mem_width_t w, input logic uns,
                                                  input logic [7:0] a);
        logic [7:0]  b;
        logic [15:0] h;
        b = ref_mem[a];
        h = {ref_mem[a + 8'd1], ref_mem[a]};
        case (w)
            mem_byte: expected_load = uns ? {24'd0, b} : {{24{b[7]}}, b};
            mem_half: expected_load = uns ? {16'd0, h} : {{16{h[15]}}, h};
            default:  expected_load = {ref_mem[a + 8'd3], ref_mem[a + 8'd2], h};
        endcase
    endfunction

    task automatic update_ref(input mem_width_t w, input logic [7:0] a, input logic [31:0] d);
        ref_mem[a] = d[7:0];
        if (w != mem_byte) ref_mem[a + 8'd1] = d[15:8];
        if (w == mem_word) begin
            ref_mem[a + 8'd2] = d[23:16];
            ref_mem[a + 8'd3] = d[31:24];
        end
    endtask

    // one access, optionally kept in mem stage by hold after it ends
    task automatic do_access(input logic wr, input mem_width_t w, input logic uns,
                             input logic [7:0] a, input logic [31:0] d, input int hold_cycles);
        mem_req_t r;
        r.en          = 1'b1;
        r.wr          = wr;
        r.width       = w;
        r.unsigned_ld = uns;
        r.addr        = {24'd0, a};
        r.wdata       = d;
        if (!wr) exp_load = expected_load(w, uns, a);
        load_check = !wr;
        mem_req    = r;
        hold       = (hold_cycles > 0);
        issued++;
        do begin
            @(posedge clk);
            #1;
        end while (stall);
        if (wr) update_ref(w, a, d);
        repeat (hold_cycles) begin
            @(posedge clk);
            #1;
        end
        hold = 1'b0;
        @(posedge clk);  // pipeline moves on here
        #1;
        assert (addr_ok_cnt == issued) else begin
            errors++;
            $display("error at %0t: addr_ok_cnt = %0d, expected %0d", $time, addr_ok_cnt, issued);
        end
    endtask

    task automatic idle(input int n);
        mem_req.en = 1'b0;
        load_check = 1'b0;
        repeat (n) begin
            @(posedge clk);
            #1;
        end
    endtask

    task automatic print_counts;
        $display("accesses %0d, addr_ok cycles %0d, errors %0d, protocol errors %0d",
                 issued, addr_ok_cnt, errors, proto_errs);
    endtask

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles == max_cycles) begin
            $display("timeout: run still going after %0d cycles", max_cycles);
            print_counts();
            $display("=== FAIL ===");
            $finish;
        end
    end

    initial begin
        int          rnd;
        int          hcyc;
        logic [31:0] dat;
        logic [7:0]  a;
        mem_width_t  w;
        seed       = 58463;
        rst        = 1'b1;
        mem_req    = '0;
        hold       = 1'b0;
        zero_delay = 1'b0;
        exp_load   = '0;
        load_check = 1'b0;
        errors     = 0;
        issued     = 0;
        for (int i = 0; i < 256; i++) ref_mem[i] = fill_byte(i);
        repeat (3) @(posedge clk);
        #1;
        rst = 1'b0;
        idle(3);  // en low right after reset

        // word store then load back
        do_access(1'b1, mem_word, 1'b0, 8'h10, 32'hdeadbeef, 0);
        do_access(1'b0, mem_word, 1'b0, 8'h10, 32'h0, 0);

        // byte and half stores merged, then sign / zero extended loads
        do_access(1'b1, mem_byte, 1'b0, 8'h20, 32'h1234_5681, 0);
        do_access(1'b1, mem_byte, 1'b0, 8'h21, 32'h0000_007f, 0);
        do_access(1'b1, mem_half, 1'b0, 8'h22, 32'hffff_8001, 0);
        do_access(1'b0, mem_word, 1'b0, 8'h20, 32'h0, 0);
        do_access(1'b0, mem_byte, 1'b0, 8'h20, 32'h0, 0);
        do_access(1'b0, mem_byte, 1'b1, 8'h20, 32'h0, 0);
        do_access(1'b0, mem_byte, 1'b0, 8'h21, 32'h0, 0);
        do_access(1'b0, mem_half, 1'b0, 8'h22, 32'h0, 0);
        do_access(1'b0, mem_half, 1'b1, 8'h22, 32'h0, 0);
        do_access(1'b0, mem_byte, 1'b1, 8'h23, 32'h0, 0);

        // hold after the access, still one request each
        do_access(1'b1, mem_word, 1'b0, 8'h30, 32'h8badf00d, 4);
        do_access(1'b0, mem_word, 1'b0, 8'h30, 32'h0, 3);
        do_access(1'b0, mem_byte, 1'b0, 8'h31, 32'h0, 5);

        // addr_ok and data_ok together, back to back
        zero_delay = 1'b1;
        do_access(1'b1, mem_word, 1'b0, 8'h40, 32'h0bad_cafe, 0);
        do_access(1'b0, mem_word, 1'b0, 8'h40, 32'h0, 0);
        do_access(1'b1, mem_half, 1'b0, 8'h44, 32'h0000_9abc, 0);
        do_access(1'b0, mem_half, 1'b1, 8'h44, 32'h0, 0);
        do_access(1'b1, mem_byte, 1'b0, 8'h47, 32'h0000_00e5, 0);
        do_access(1'b0, mem_word, 1'b0, 8'h44, 32'h0, 0);
        do_access(1'b0, mem_byte, 1'b0, 8'h47, 32'h0, 0);
        do_access(1'b0, mem_half, 1'b0, 8'h46, 32'h0, 0);
        zero_delay = 1'b0;

        // mixed random traffic with random bus delays
        for (int i = 0; i < n_random; i++) begin
            rnd  = $random(seed);
            dat  = $random(seed);
            w    = pick_width(rnd[1:0]);
            a    = rnd[15:8];
            hcyc = (rnd[6:4] == 3'd7) ? 2 : 0;
            if (w == mem_half) a[0] = 1'b0;
            if (w == mem_word) a[1:0] = 2'b00;
            do_access(rnd[2], w, rnd[3], a, dat, hcyc);
        end
        idle(3);

        print_counts();
        if (errors == 0 && proto_errs == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== sim/sram_like_mem.sv ====
`timescale 1ns/1ps
`default_nettype none

module sram_like_mem (
    input  logic                clk,
    input  logic                rst,
    input  logic                zero_delay,  // addr_ok and data_ok in one cycle
    input  dmem_pkg::bus_req_t  bus_req,
    output dmem_pkg::bus_resp_t bus_resp
);

    import dmem_pkg::*;

    localparam int n_words = 64;  // 256 bytes

    logic [31:0] mem [0:n_words-1];
    logic        busy;     // address taken, data phase open
    logic [1:0]  a_cnt;    // cycles left before addr_ok
    logic [1:0]  d_cnt;    // cycles from addr_ok to data_ok
    bus_req_t    held;     // request captured on addr_ok
    bus_req_t    cur;      // access served this cycle
    logic        addr_ok;
    logic        data_ok;
    logic [3:0]  be;       // byte lanes written
    logic [5:0]  idx;      // word index
    integer      seed;
    int          rnd;

    // start content, every byte from its own address
    function automatic logic [7:0] fill_byte(input int a);
        fill_byte = a[7:0] * 8'd29 ^ 8'hc3;
    endfunction

    initial begin
        seed = 58463;
        for (int i = 0; i < n_words; i++) begin
            for (int k = 0; k < 4; k++) begin
                mem[i][8*k +: 8] = fill_byte(4*i + k);
            end
        end
    end

    assign cur     = busy ? held : bus_req;
    assign idx     = cur.addr[7:2];
    assign addr_ok = bus_req.req & ~busy & (zero_delay | (a_cnt == 2'd0));
    // data may come with the addr_ok itself
    assign data_ok = busy ? (d_cnt == 2'd0) : (addr_ok & (zero_delay | (d_cnt == 2'd0)));

    always_comb begin
        case (cur.size)
            2'd0:    be = 4'b0001 << cur.addr[1:0];
            2'd1:    be = cur.addr[1] ? 4'b1100 : 4'b0011;
            default: be = 4'b1111;
        endcase
        bus_resp.addr_ok = addr_ok;
        bus_resp.data_ok = data_ok;
        bus_resp.rdata   = mem[idx];  // whole word, unshifted
    end

    always @(posedge clk) begin
        if (rst) begin
            busy  <= 1'b0;
            a_cnt <= 2'd1;
            d_cnt <= 2'd1;
        end else if (data_ok) begin
            busy <= 1'b0;
            rnd = $random(seed);  // delays for the next access
            a_cnt <= rnd[1:0];
            d_cnt <= rnd[3:2];
            for (int k = 0; k < 4; k++) begin
                if (cur.wr && be[k]) mem[idx][8*k +: 8] <= cur.wdata[8*k +: 8];
            end
        end else if (addr_ok) begin
            busy  <= 1'b1;
            held  <= bus_req;
            d_cnt <= d_cnt - 2'd1;
        end else if (busy) begin
            d_cnt <= d_cnt - 2'd1;
        end else if (bus_req.req) begin
            a_cnt <= a_cnt - 2'd1;  // slave still busy elsewhere
        end
    end

endmodule

`default_nettype wire

// ==== src/dmem_pkg.sv ====
`default_nettype none

`include "dmem_settings.svh"

package dmem_pkg;

    // access width from the decoded load/store opcode
    typedef enum logic [1:0] {
        mem_byte = 2'd0,            // lb / lbu / sb
        mem_half = 2'd1,            // lh / lhu / sh
        mem_word = 2'd2             // lw / sw
    } mem_width_t;

    // memory-stage request, stable while stall is high
    typedef struct packed {
        logic                    en;          // load or store in mem stage
        logic                    wr;          // 1 = store
        mem_width_t              width;
        logic                    unsigned_ld; // lbu / lhu
        logic [`DMEM_ADDR_W-1:0] addr;        // aligned byte address
        logic [`DMEM_DATA_W-1:0] wdata;       // store data, low bits used
    } mem_req_t;

    // outgoing sram-like request
    typedef struct packed {
        logic                    req;   // held until addr_ok
        logic                    wr;
        logic [1:0]              size;  // 0 byte, 1 half, 2 word
        logic [`DMEM_ADDR_W-1:0] addr;
        logic [`DMEM_DATA_W-1:0] wdata; // lane replicated
    } bus_req_t;

    // incoming sram-like response
    typedef struct packed {
        logic                    addr_ok; // address accepted
        logic                    data_ok; // read data valid / write done
        logic [`DMEM_DATA_W-1:0] rdata;   // whole word, not shifted
    } bus_resp_t;

endpackage

`default_nettype wire

// ==== src/dmem_port_top.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "dmem_settings.svh"

module dmem_port_top (
    input  logic                    clk,
    input  logic                    rst,
    input  dmem_pkg::mem_req_t      mem_req,
    input  logic                    hold,
    output logic                    stall,
    output logic [`DMEM_DATA_W-1:0] load_data,
    output dmem_pkg::bus_req_t      bus_req,
    input  dmem_pkg::bus_resp_t     bus_resp
);

    import dmem_pkg::*;

    logic [1:0]              st_size;     // bus size code
    logic [`DMEM_DATA_W-1:0] st_wdata;    // lane replicated store data
    logic [`DMEM_DATA_W-1:0] rdata_hold;  // word kept after data_ok

    // store side, combinational
    store_align i_store_align (
        .mem_req (mem_req),
        .size    (st_size),
        .wdata   (st_wdata)
    );

    // handshake and stall control
    sram_like_bridge i_bridge (
        .clk        (clk),
        .rst        (rst),
        .mem_req    (mem_req),
        .size       (st_size),
        .wdata      (st_wdata),
        .hold       (hold),
        .stall      (stall),
        .bus_req    (bus_req),
        .bus_resp   (bus_resp),
        .rdata_hold (rdata_hold)
    );

    // load side, uses the still-stable mem stage request
    load_extend i_load_extend (
        .word        (rdata_hold),
        .width       (mem_req.width),
        .unsigned_ld (mem_req.unsigned_ld),
        .offset      (mem_req.addr[1:0]),
        .load_data   (load_data)
    );

endmodule

`default_nettype wire

// ==== src/dmem_settings.svh ====
`ifndef DMEM_SETTINGS_SVH
`define DMEM_SETTINGS_SVH

// widths of the data-memory port

// byte address from the memory stage
`define DMEM_ADDR_W 32

// one bus word
// lane logic assumes a multiple of 16
`define DMEM_DATA_W 32

`endif

// ==== src/load_extend.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "dmem_settings.svh"

module load_extend (
    input  logic [`DMEM_DATA_W-1:0] word,        // held read word
    input  dmem_pkg::mem_width_t    width,
    input  logic                    unsigned_ld,
    input  logic [1:0]              offset,      // addr[1:0]
    output logic [`DMEM_DATA_W-1:0] load_data
);

    import dmem_pkg::*;

    logic [7:0]  sel_byte;   // addressed byte
    logic [15:0] sel_half;   // addressed half
    logic        byte_fill;  // extension bit for byte loads
    logic        half_fill;  // extension bit for half loads

    // lane select, little endian
    assign sel_byte = word[{offset, 3'b000} +: 8];
    assign sel_half = offset[1] ? word[31:16] : word[15:0];

    // zero fill for lbu / lhu
    assign byte_fill = ~unsigned_ld & sel_byte[7];
    assign half_fill = ~unsigned_ld & sel_half[15];

    always_comb begin
        case (width)
            mem_byte: load_data = {{(`DMEM_DATA_W-8){byte_fill}}, sel_byte};
            mem_half: load_data = {{(`DMEM_DATA_W-16){half_fill}}, sel_half};
            mem_word: load_data = word;
            default:  load_data = word;  // unused code
        endcase
    end

endmodule

`default_nettype wire

// ==== src/sram_like_bridge.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "dmem_settings.svh"

module sram_like_bridge (
    input  logic                    clk,
    input  logic                    rst,
    input  dmem_pkg::mem_req_t      mem_req,
    input  logic [1:0]              size,       // from store_align
    input  logic [`DMEM_DATA_W-1:0] wdata,      // from store_align
    input  logic                    hold,       // pipeline held elsewhere
    output logic                    stall,
    output dmem_pkg::bus_req_t      bus_req,
    input  dmem_pkg::bus_resp_t     bus_resp,
    output logic [`DMEM_DATA_W-1:0] rdata_hold  // last read word
);

    import dmem_pkg::*;

    logic addr_rcv;   // address phase done, waiting for data_ok
    logic finished;   // access done, pipeline not yet moved on
    logic req_int;

    // request only for a fresh access
    assign req_int = mem_req.en & ~addr_rcv & ~finished;

    // address handshake
    // addr_ok together with data_ok means the data_ok wins
    // and the access is already over, so no address-received state
    always_ff @(posedge clk) begin
        if (rst) begin
            addr_rcv <= 1'b0;
        end else if (req_int && bus_resp.addr_ok && !bus_resp.data_ok) begin
            addr_rcv <= 1'b1;
        end else if (bus_resp.data_ok) begin
            addr_rcv <= 1'b0;   // data phase closed
        end
    end

    // finished stays up while hold keeps the same request
    // in the mem stage, otherwise en would start a second access
    always_ff @(posedge clk) begin
        if (rst) begin
            finished <= 1'b0;
        end else if (bus_resp.data_ok) begin
            finished <= 1'b1;
        end else if (!hold) begin
            finished <= 1'b0;   // pipeline advances this cycle
        end
    end

    // read word kept until the next data_ok
    always_ff @(posedge clk) begin
        if (rst) begin
            rdata_hold <= '0;
        end else if (bus_resp.data_ok) begin
            rdata_hold <= bus_resp.rdata;
        end
    end

    // outgoing request, fields straight from the mem stage
    always_comb begin
        bus_req.req   = req_int;
        bus_req.wr    = mem_req.en & mem_req.wr;
        bus_req.size  = size;
        bus_req.addr  = mem_req.addr;
        bus_req.wdata = wdata;
    end

    // falls one cycle after data_ok
    assign stall = mem_req.en & ~finished;

endmodule

`default_nettype wire

// ==== src/store_align.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "dmem_settings.svh"

module store_align (
    input  dmem_pkg::mem_req_t       mem_req,
    output logic [1:0]               size,  // bus size code
    output logic [`DMEM_DATA_W-1:0]  wdata  // data copied into every lane
);

    import dmem_pkg::*;

    // sram-like size encoding
    localparam logic [1:0] size_byte = 2'd0;
    localparam logic [1:0] size_half = 2'd1;
    localparam logic [1:0] size_word = 2'd2;

    localparam int n_bytes = `DMEM_DATA_W / 8;
    localparam int n_halves = `DMEM_DATA_W / 16;

    // low parts of the store data
    logic [7:0]  st_byte;
    logic [15:0] st_half;

    assign st_byte = mem_req.wdata[7:0];
    assign st_half = mem_req.wdata[15:0];

    // slave picks the lane from addr and size, so
    // every lane of the access width gets the same value
    always_comb begin
        case (mem_req.width)
            mem_byte: begin
                size  = size_byte;
                wdata = {n_bytes{st_byte}};     // sb: b b b b
            end
            mem_half: begin
                size  = size_half;
                wdata = {n_halves{st_half}};    // sh: h h
            end
            mem_word: begin
                size  = size_word;
                wdata = mem_req.wdata;          // sw: as is
            end
            default: begin
                // unused enum code, treat as word
                size  = size_word;
                wdata = mem_req.wdata;
            end
        endcase
    end

endmodule

`default_nettype wire

// ==== vlog.f ====
+incdir+src
src/dmem_pkg.sv
src/store_align.sv
src/load_extend.sv
src/sram_like_bridge.sv
src/dmem_port_top.sv
sim/sram_like_mem.sv
sim/dmem_port_assert.sv
sim/dmem_port_tb.sv
